/* common/cpuPkg.sv */
package cpuPkg;

   // register and bus width
   localparam int dataWidth = 16;

   localparam int regAddrWidth = 3;
   localparam int numRegs = 2 ** regAddrWidth;

endpackage

/* common/isaPkg.sv */
package isaPkg;

   // instruction class, bits 15:14
   localparam logic [1:0] clsLoad  = 2'b00;
   localparam logic [1:0] clsStore = 2'b01;
   localparam logic [1:0] clsImm   = 2'b10;
   localparam logic [1:0] clsArith = 2'b11;

   // op field of the arithmetic class
   localparam logic [3:0] opAdd = 4'd0;
   localparam logic [3:0] opSub = 4'd1;
   localparam logic [3:0] opAnd = 4'd2;
   localparam logic [3:0] opOr  = 4'd3;
   localparam logic [3:0] opXor = 4'd4;
   localparam logic [3:0] opCmp = 4'd5;
   localparam logic [3:0] opMov = 4'd6;
   localparam logic [3:0] opSll = 4'd8;
   localparam logic [3:0] opSlr = 4'd9;
   localparam logic [3:0] opSrl = 4'd10;
   localparam logic [3:0] opSra = 4'd11;
   localparam logic [3:0] opIn  = 4'd12;
   localparam logic [3:0] opOut = 4'd13;
   localparam logic [3:0] opHlt = 4'd15;

   // ALU select, same values as the op field where they overlap
   localparam logic [3:0] aluAdd  = 4'd0;
   localparam logic [3:0] aluSub  = 4'd1;
   localparam logic [3:0] aluAnd  = 4'd2;
   localparam logic [3:0] aluOr   = 4'd3;
   localparam logic [3:0] aluXor  = 4'd4;
   localparam logic [3:0] aluSll  = 4'd8;
   localparam logic [3:0] aluSlr  = 4'd9;
   localparam logic [3:0] aluSrl  = 4'd10;
   localparam logic [3:0] aluSra  = 4'd11;
   localparam logic [3:0] aluPass = 4'd12; // result is operand B
   localparam logic [3:0] aluNone = 4'd15;

   localparam logic [2:0] immLi   = 3'b000;
   localparam logic [2:0] immAddi = 3'b001;
   localparam logic [2:0] immBr   = 3'b100;
   localparam logic [2:0] immBcc  = 3'b111;

   localparam logic [2:0] condEq     = 3'b000;
   localparam logic [2:0] condLt     = 3'b001;
   localparam logic [2:0] condLe     = 3'b010;
   localparam logic [2:0] condNe     = 3'b011;
   localparam logic [2:0] condCs     = 3'b100; // carry set
   localparam logic [2:0] condAlways = 3'b111; // decoder drives this for plain B

   typedef union packed {
      struct packed {
         logic [1:0] cls;
         logic [2:0] rs;
         logic [2:0] rd;
         logic [3:0] op;
         logic [3:0] shamt;
      } arith;
      struct packed {
         logic [1:0] cls;
         logic [2:0] ra;   // op2 in the immediate class
         logic [2:0] rb;   // cond for BE
         logic [7:0] disp;
      } imm;
   } instrWord;

endpackage

/* decode/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit (
   input  isaPkg::instrWord                instr,
   output logic                            signEx,
   output logic                            arMux,
   output logic                            brMux,
   output logic [3:0]                      aluSel,
   output logic                            inputMux,
   output logic                            writeEnable,
   output logic                            regWrite,
   output logic [cpuPkg::regAddrWidth-1:0] writeAddress,
   output logic                            adrMux,
   output logic                            pcLoad,
   output logic [2:0]                      cond,
   output logic                            flagWrite,
   output logic                            outStrobe,
   output logic                            halt
);

   import isaPkg::*;

   always_comb begin
      signEx       = 1'b0;
      arMux        = 1'b1;
      brMux        = 1'b1;
      aluSel       = aluNone;
      inputMux     = 1'b0;
      writeEnable  = 1'b0;
      regWrite     = 1'b0;
      writeAddress = instr.arith.rd;
      adrMux       = 1'b1; // write-back from the ALU
      pcLoad       = 1'b0;
      cond         = condAlways;
      flagWrite    = 1'b0;
      outStrobe    = 1'b0;
      halt         = 1'b0;

      case (instr.arith.cls)
         clsLoad: begin
            writeAddress = instr.imm.ra; // load target is Ra
            brMux        = 1'b0;
            aluSel       = aluAdd;
            regWrite     = 1'b1;
            adrMux       = 1'b0;
         end
         clsStore: begin
            brMux       = 1'b0;
            aluSel      = aluAdd;
            writeEnable = 1'b1;
         end
         clsImm: begin
            signEx = 1'b1;
            brMux  = 1'b0;
            case (instr.imm.ra)
               immLi: begin
                  aluSel   = aluPass;
                  regWrite = 1'b1;
               end
               immAddi: begin
                  aluSel   = aluAdd;
                  regWrite = 1'b1;
               end
               immBr: begin
                  arMux  = 1'b0; // PC+1 plus disp
                  aluSel = aluAdd;
                  pcLoad = 1'b1;
               end
               immBcc: begin
                  arMux  = 1'b0;
                  aluSel = aluAdd;
                  pcLoad = 1'b1;
                  cond   = instr.imm.rb;
               end
               default: ;
            endcase
         end
         clsArith: begin
            case (instr.arith.op)
               opAdd, opSub, opAnd, opOr, opXor, opSll, opSlr, opSrl, opSra: begin
                  aluSel    = instr.arith.op;
                  regWrite  = 1'b1;
                  flagWrite = 1'b1;
               end
               opCmp: begin
                  aluSel    = aluSub; // flags only
                  flagWrite = 1'b1;
               end
               opMov: begin
                  aluSel    = aluPass;
                  regWrite  = 1'b1;
                  flagWrite = 1'b1;
               end
               opIn: begin
                  inputMux = 1'b1;
                  regWrite = 1'b1;
               end
               opOut:   outStrobe = 1'b1;
               opHlt:   halt = 1'b1;
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

/* execute/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         phase,
   input  logic [3:0]                   aluSel,
   input  logic                         arMux,
   input  logic                         brMux,
   input  logic                         signEx,
   input  logic [cpuPkg::dataWidth-1:0] regA,
   input  logic [cpuPkg::dataWidth-1:0] regB,
   input  logic [cpuPkg::dataWidth-1:0] pc,
   input  logic [7:0]                   disp,
   input  logic [3:0]                   shamt,
   input  logic                         flagWrite,
   input  logic [2:0]                   cond,
   input  logic                         pcLoad,
   output logic [cpuPkg::dataWidth-1:0] aluResult,
   output logic                         condMet
);

   import isaPkg::*;
   import cpuPkg::*;

   localparam int msb = dataWidth - 1;

   logic [dataWidth-1:0]   opA, opB, immExt;
   logic [dataWidth:0]     sum;     // carry in the top bit
   logic [2*dataWidth-1:0] rotWide;
   logic                   carry, overflow;
   logic                   flagS, flagZ, flagC, flagV;
   logic                   condTrue;

   assign immExt = signEx ? {{(dataWidth-8){disp[7]}}, disp} : {{(dataWidth-8){1'b0}}, disp};
   assign opA = arMux ? regA : pc;
   assign opB = brMux ? regB : immExt;

   always_comb begin
      sum       = '0;
      rotWide   = {opA, opA} << shamt;
      carry     = 1'b0;
      overflow  = 1'b0;
      aluResult = '0;
      case (aluSel)
         aluAdd: begin
            sum       = {1'b0, opA} + {1'b0, opB};
            aluResult = sum[msb:0];
            carry     = sum[dataWidth];
            overflow  = (opA[msb] == opB[msb]) && (sum[msb] != opA[msb]);
         end
         aluSub: begin
            sum       = {1'b0, opA} - {1'b0, opB};
            aluResult = sum[msb:0];
            carry     = sum[dataWidth]; // borrow
            overflow  = (opA[msb] != opB[msb]) && (sum[msb] != opA[msb]);
         end
         aluAnd:  aluResult = opA & opB;
         aluOr:   aluResult = opA | opB;
         aluXor:  aluResult = opA ^ opB;
         aluSll:  aluResult = opA << shamt;
         aluSlr:  aluResult = rotWide[2*dataWidth-1:dataWidth]; // rotate left
         aluSrl:  aluResult = opA >> shamt;
         aluSra:  aluResult = $signed(opA) >>> shamt;
         aluPass: aluResult = opB;
         default: aluResult = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         {flagS, flagZ, flagC, flagV} <= '0;
      end else if (phase && flagWrite) begin
         flagS <= aluResult[msb];
         flagZ <= (aluResult == '0);
         flagC <= carry;
         flagV <= overflow;
      end
   end

   // conditions look at flags from earlier instructions
   always_comb begin
      case (cond)
         condEq:     condTrue = flagZ;
         condLt:     condTrue = flagS ^ flagV;
         condLe:     condTrue = flagZ | (flagS ^ flagV);
         condNe:     condTrue = !flagZ;
         condCs:     condTrue = flagC;
         condAlways: condTrue = 1'b1;
         default:    condTrue = 1'b0;
      endcase
   end

   assign condMet = pcLoad && condTrue;

endmodule

/* execute/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            phase,
   input  logic                            regWrite,
   input  logic [cpuPkg::regAddrWidth-1:0] writeAddress,
   input  logic [cpuPkg::dataWidth-1:0]    writeData,
   input  logic [cpuPkg::regAddrWidth-1:0] rsAddr,
   input  logic [cpuPkg::regAddrWidth-1:0] rdAddr,
   output logic [cpuPkg::dataWidth-1:0]    rsData,
   output logic [cpuPkg::dataWidth-1:0]    rdData
);

   import cpuPkg::*;

   logic [dataWidth-1:0] regs [numRegs];

   // written on the execute edge only
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < numRegs; i++)
            regs[i] <= '0;
      end else if (phase && regWrite) begin
         regs[writeAddress] <= writeData;
      end
   end

   assign rsData = regs[rsAddr];
   assign rdData = regs[rdAddr];

endmodule

/* fetch/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit #(
   parameter int imemAddrWidth = 8
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  logic                     progWe,
   input  logic [imemAddrWidth-1:0] progAddr,
   input  isaPkg::instrWord         progData,
   input  logic                     halted,
   input  logic                     pcLoad,
   input  logic                     condMet,
   input  logic [imemAddrWidth-1:0] branchTarget,
   output isaPkg::instrWord         instr,
   output logic [imemAddrWidth-1:0] pc,
   output logic                     phase
);

   import isaPkg::*;

   instrWord imem [2**imemAddrWidth];
   logic     running;

   assign running = run && !halted;

   // host load, only while stopped
   always_ff @(posedge clk) begin
      if (progWe && !run)
         imem[progAddr] <= progData;
   end

   always_ff @(posedge clk) begin
      if (running && !phase)
         instr <= imem[pc]; // fetch edge
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc    <= '0;
         phase <= 1'b0;
      end else if (!run) begin
         pc    <= '0; // restart from 0 on the next run
         phase <= 1'b0;
      end else if (!halted) begin
         phase <= !phase;
         if (phase) begin
            if (pcLoad && condMet)
               pc <= branchTarget;
            else
               pc <= pc + imemAddrWidth'(1);
         end
      end
   end

endmodule

/* hdl/memoryIo.sv */
`timescale 1ns/1ps

module memoryIo #(
   parameter int dmemAddrWidth = 8
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         phase,
   input  logic                         writeEnable,
   input  logic [cpuPkg::dataWidth-1:0] address,
   input  logic [cpuPkg::dataWidth-1:0] storeData,
   input  logic                         outStrobe,
   input  logic                         halt,
   output logic [cpuPkg::dataWidth-1:0] loadData,
   output logic [cpuPkg::dataWidth-1:0] outData,
   output logic                         outValid,
   output logic                         halted
);

   import cpuPkg::*;

   logic [dataWidth-1:0]     dmem [2**dmemAddrWidth];
   logic [dmemAddrWidth-1:0] memAddr;

   assign memAddr = address[dmemAddrWidth-1:0]; // upper bits wrap

   always_ff @(posedge clk) begin
      if (phase && writeEnable)
         dmem[memAddr] <= storeData;
   end

   assign loadData = dmem[memAddr];

   // OUT value holds until the next OUT
   always_ff @(posedge clk) begin
      if (phase && outStrobe)
         outData <= storeData;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         outValid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         outValid <= phase && outStrobe; // drops on the following fetch edge
         if (phase && halt)
            halted <= 1'b1;
      end
   end

endmodule

/* hdl/simpleCore.sv */
`timescale 1ns/1ps

module simpleCore #(
   parameter int imemAddrWidth = 8,
   parameter int dmemAddrWidth = 8
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         progWe,
   input  logic [imemAddrWidth-1:0]     progAddr,
   input  isaPkg::instrWord             progData,
   input  logic                         run,
   input  logic [cpuPkg::dataWidth-1:0] inData,
   output logic [cpuPkg::dataWidth-1:0] outData,
   output logic                         outValid,
   output logic                         halted
);

   import isaPkg::*;
   import cpuPkg::*;

   instrWord                 instr;
   logic [imemAddrWidth-1:0] pc, branchTarget;
   logic                     phase;
   logic                     signEx, arMux, brMux, inputMux, writeEnable, regWrite;
   logic                     adrMux, pcLoad, flagWrite, outStrobe, halt, condMet;
   logic [3:0]               aluSel;
   logic [2:0]               cond;
   logic [regAddrWidth-1:0]  writeAddress;
   logic [dataWidth-1:0]     rsData, rdData, aluResult, loadData, writeData, pcPlusOne;

   // branches add disp to PC+1
   assign pcPlusOne = dataWidth'(pc) + dataWidth'(1);
   assign branchTarget = aluResult[imemAddrWidth-1:0];

   assign writeData = inputMux ? inData : (adrMux ? aluResult : loadData);

   fetchUnit #(.imemAddrWidth(imemAddrWidth)) fetch (
      .clk, .rst, .run, .progWe, .progAddr, .progData, .halted,
      .pcLoad, .condMet, .branchTarget, .instr, .pc, .phase
   );

   decodeUnit decode (
      .instr, .signEx, .arMux, .brMux, .aluSel, .inputMux, .writeEnable,
      .regWrite, .writeAddress, .adrMux, .pcLoad, .cond, .flagWrite,
      .outStrobe, .halt
   );

   registerFile regFile (
      .clk, .rst, .phase, .regWrite, .writeAddress, .writeData,
      .rsAddr (instr.arith.rs),
      .rdAddr (instr.arith.rd),
      .rsData, .rdData
   );

   aluUnit alu (
      .clk, .rst, .phase, .aluSel, .arMux, .brMux, .signEx,
      .regA  (rdData), // Rb side, also the base address
      .regB  (rsData),
      .pc    (pcPlusOne),
      .disp  (instr.imm.disp),
      .shamt (instr.arith.shamt),
      .flagWrite, .cond, .pcLoad, .aluResult, .condMet
   );

   memoryIo #(.dmemAddrWidth(dmemAddrWidth)) memIo (
      .clk, .rst, .phase, .writeEnable,
      .address   (aluResult),
      .storeData (rsData),
      .outStrobe, .halt, .loadData, .outData, .outValid, .halted
   );

endmodule

/* verification/coreTb.sv */
`timescale 1ns/1ps

module coreTb;

   import isaPkg::*;

   localparam logic [3:0] aluOpList [11] = '{opAdd, opSub, opAnd, opOr, opXor, opMov,
                                              opSll, opSlr, opSrl, opSra, opCmp};

   logic        clk, rst, progWe, run, outValid, halted;
   logic [7:0]  progAddr;
   instrWord    progData;
   logic [15:0] inData, outData;
   logic [15:0] prog [256];
   logic [15:0] inSeq [256]; // inData value per executed instruction
   logic [15:0] outExp [$];
   int          progLen;

   simpleCore #(.imemAddrWidth(8), .dmemAddrWidth(8)) uut (
      .clk, .rst, .progWe, .progAddr, .progData, .run, .inData, .outData, .outValid, .halted
   );

   always #5 clk = ~clk;

   task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("ERROR: %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("test failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic addInstr(input logic [15:0] w);
      prog[progLen] = w;
      progLen++;
   endtask

   // branches only skip the first OUT of their own block
   task automatic buildProgram();
      logic [2:0] x, y, z, d;
      progLen = 0;
      for (int i = 0; i < 8; i++)
         addInstr({clsImm, immLi, 3'(i), 8'($urandom)});
      repeat (30) begin
         x = 3'($urandom);
         y = 3'($urandom);
         z = 3'($urandom);
         d = 3'($urandom);
         case ($urandom % 5)
            0: begin
               addInstr({clsArith, y, x, aluOpList[$urandom % 11], 4'($urandom)});
               addInstr({clsImm, immAddi, z, 8'($urandom)});
            end
            1: begin
               addInstr({clsImm, immLi, x, 8'($urandom % 100)}); // base address
               addInstr({clsStore, y, x, 8'd0});
               addInstr({clsStore, z, x, 8'd1});
               addInstr({clsLoad, d, x, 7'd0, 1'($urandom)});
               addInstr({clsArith, d, 3'd0, opOut, 4'd0});
            end
            2: begin
               addInstr({clsArith, 3'd0, x, opIn, 4'd0});
               addInstr({clsArith, x, 3'd0, opOut, 4'd0});
            end
            3: begin
               addInstr({clsArith, y, x, (d[0] ? opCmp : aluOpList[$urandom % 11]),
                         4'($urandom)});
               addInstr({clsImm, immBcc, 3'($urandom % 4), 8'd1});
               addInstr({clsArith, y, 3'd0, opOut, 4'd0});
               addInstr({clsArith, z, 3'd0, opOut, 4'd0});
            end
            default: begin
               addInstr({clsImm, immBr, 3'd0, 8'd1});
               addInstr({clsArith, y, 3'd0, opOut, 4'd0});
               addInstr({clsArith, z, 3'd0, opOut, 4'd0});
            end
         endcase
      end
      for (int i = 0; i < 8; i++)
         addInstr({clsArith, 3'(i), 3'd0, opOut, 4'd0}); // dump final registers
      addInstr({clsArith, 3'd0, 3'd0, opHlt, 4'd0});
      for (int i = 0; i < 256; i++)
         inSeq[i] = 16'($urandom);
   endtask

   // instruction-level reference, fills the expected OUT queue
   task automatic runModel();
      logic [15:0] r [8];
      logic [15:0] mem [256];
      logic [15:0] w, a, b, res;
      logic [7:0]  pc, addr;
      logic        fs, fz, fv, take, done;
      int          k, sInt;
      r = '{default: '0};
      {fs, fz, fv, done} = '0;
      pc = '0;
      k = 0;
      outExp.delete();
      while (!done && k < 1000) begin
         w = prog[pc];
         a = r[w[10:8]]; // rd field, also the base register
         b = r[w[13:11]];
         addr = a[7:0] + w[7:0];
         pc = pc + 8'd1;
         res = '0;
         sInt = 0;
         case (w[10:8])
            condEq:  take = fz;
            condLt:  take = fs ^ fv;
            condLe:  take = fz | (fs ^ fv);
            default: take = !fz;
         endcase
         case (w[15:14])
            clsLoad:  r[w[13:11]] = mem[addr];
            clsStore: mem[addr] = b;
            clsImm: begin
               if (w[13:11] == immLi)
                  r[w[10:8]] = {{8{w[7]}}, w[7:0]};
               else if (w[13:11] == immAddi)
                  r[w[10:8]] = a + {{8{w[7]}}, w[7:0]};
               else if (w[13:11] == immBr || (w[13:11] == immBcc && take))
                  pc = pc + w[7:0];
            end
            default: begin
               case (w[7:4])
                  opAdd: begin
                     res = a + b;
                     sInt = $signed(a) + $signed(b);
                  end
                  opSub, opCmp: begin
                     res = a - b;
                     sInt = $signed(a) - $signed(b);
                  end
                  opAnd: res = a & b;
                  opOr:  res = a | b;
                  opXor: res = a ^ b;
                  opMov: res = b;
                  opSll: res = a << w[3:0];
                  opSlr: res = (a << w[3:0]) | (a >> (16 - w[3:0]));
                  opSrl: res = a >> w[3:0];
                  opSra: res = $signed(a) >>> w[3:0];
                  opIn:  r[w[10:8]] = inSeq[k]; // two cycles per instruction
                  opOut: outExp.push_back(b);
                  opHlt: done = 1'b1;
                  default: ;
               endcase
               if (w[7:4] <= opMov || (w[7:4] >= opSll && w[7:4] <= opSra)) begin
                  fs = res[15];
                  fz = (res == '0);
                  fv = (sInt > 32767) || (sInt < -32768);
                  if (w[7:4] != opCmp)
                     r[w[10:8]] = res;
               end
            end
         endcase
         k++;
      end
   endtask

   task automatic resetCore();
      run = 1'b0;
      rst = 1'b1;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      checkValue(halted, 0, "halted after reset");
   endtask

   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         progWe = 1'b1;
         progAddr = 8'(i);
         progData = prog[i];
         @(negedge clk);
      end
      progWe = 1'b0;
   endtask

   task automatic runAndCheck();
      int cyc, limit, outIdx;
      limit = 2 * progLen * 2 + 100;
      cyc = 0;
      outIdx = 0;
      run = 1'b1;
      while (!halted) begin
         inData = inSeq[(cyc >> 1) % 256];
         @(negedge clk);
         cyc++;
         if (outValid) begin
            if (outIdx >= outExp.size())
               checkValue(outIdx + 1, outExp.size(), "OUT pulse count");
            checkValue(outData, outExp[outIdx], "OUT value");
            outIdx++;
         end
         if (cyc > limit) begin
            $display("timeout: the core did not halt within %0d cycles", limit);
            $display("test failed");
            $fatal(1, "timeout");
         end
      end
      checkValue(outIdx, outExp.size(), "OUT pulse count");
      repeat (10) begin
         @(negedge clk);
         checkValue(outValid, 0, "outValid after halt");
         checkValue(halted, 1, "halted level");
      end
   endtask

   initial begin
      void'($urandom(6));
      clk = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      inData = '0;
      repeat (2) begin // second program after rst
         resetCore();
         buildProgram();
         runModel();
         loadProgram();
         runAndCheck();
      end
      if (uut.chk.failCount == 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("%0d assertion failures were reported", uut.chk.failCount);
         $display("test failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

/* verification/simpleCore_asserts.sv */
`timescale 1ns/1ps

module simpleCore_asserts (
   input logic clk,
   input logic rst,
   input logic outValid,
   input logic halted
);

   int failCount = 0; // read by the testbench at the end

   outPulse: assert property (@(posedge clk) outValid |=> !outValid)
      else begin
         failCount++;
         $error("outValid high for two cycles");
      end

   haltSticky: assert property (@(posedge clk) halted && !rst |=> halted)
      else begin
         failCount++;
         $error("halted dropped without rst");
      end

   resetQuiet: assert property (@(posedge clk) rst |=> !outValid)
      else begin
         failCount++;
         $error("outValid high during reset");
      end

endmodule

bind simpleCore simpleCore_asserts chk (.clk, .rst, .outValid, .halted);

/* verilog.f */
common/isaPkg.sv
common/cpuPkg.sv
fetch/fetchUnit.sv
decode/decodeUnit.sv
execute/registerFile.sv
execute/aluUnit.sv
hdl/memoryIo.sv
hdl/simpleCore.sv
verification/simpleCore_asserts.sv
verification/coreTb.sv
